// ==== include/wb_defs.svh ====
// ==================================================
// Shared memory latency bound, in cycles per grant
// The memory model and the top level checks use it
// ==================================================
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Worst-case delay from request to data_gnt
`define WB_MEM_LAT_MAX 4

`endif

// ==== source/wb_pkg.sv ====
// ==================================================
// Types shared by the write-back stage
// Memory side is word-addressed, 32-bit data
// ==================================================
package wb_pkg;

    // Memory access size
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } access_size_t;

    // Control bits from execute
    typedef struct packed {
        logic [4:0]   rd;
        logic         rd_write;
        logic         branch;
        logic         branch_cond;
        logic         ld;
        logic         st;
        access_size_t data_size;
        logic         data_sign;
        logic         illegal;
    } wb_ctrl_t;

    // Execute to write-back bundle
    // result1 holds the value or address
    // result2 holds the branch target or store data
    typedef struct packed {
        logic [31:0] result1;
        logic [31:0] result2;
        wb_ctrl_t    ctrl;
    } ex_wb_t;

    // Word-aligned memory request
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wr_data;
        logic        rd_req;
        logic        wr_req;
    } mem_req_t;

    // Sequencer states
    typedef enum logic [2:0] {
        WRITE,
        READ,
        STORE_WR,
        LOAD,
        CATCH
    } wb_state_t;

endpackage

// ==== source/wb_sequencer.sv ====
// ==================================================
// Write-back FSM, one word access at a time
// Illegal bundle parks the stage until reset
// ==================================================
`timescale 1ns/1ns

module wb_sequencer
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rstz,
    input  ex_wb_t    execute,
    input  logic      pipe_in_vld,
    input  logic      data_gnt,
    input  logic      is_unaligned,
    input  logic      last_access,
    output logic      pipe_in_rdy,
    output wb_state_t state,
    output logic      accept,
    output logic      rd_req,
    output logic      wr_req
);

wb_state_t next_state;

// Current transaction is a store
logic store_op;

// ==================================================
// Handshake

// Only accept in WRITE, never an illegal bundle
assign pipe_in_rdy = (state == WRITE) && ~execute.ctrl.illegal;
assign accept      = pipe_in_rdy && pipe_in_vld;

// ==================================================
// State register

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        state    <= WRITE;
        store_op <= 1'b0;
    end else begin
        state <= next_state;
        if (accept) begin
            store_op <= execute.ctrl.st;
        end
    end
end

always_comb begin
    next_state = state;
    case (state)
        WRITE: begin
            if (pipe_in_vld && execute.ctrl.illegal) begin
                next_state = CATCH;
            end else if (accept && (execute.ctrl.ld || execute.ctrl.st)) begin
                next_state = READ;
            end
        end
        // Store goes on to the write, load may need a second word
        READ: begin
            if (data_gnt) begin
                if (store_op) next_state = STORE_WR;
                else if (last_access) next_state = LOAD;
            end
        end
        STORE_WR: begin
            if (data_gnt) begin
                next_state = last_access ? WRITE : READ;
            end
        end
        // Register write of the load result
        LOAD: next_state = WRITE;
        default: next_state = CATCH;
    endcase
end

// ==================================================
// Memory requests

// Read issued in the accept cycle, second load word looked ahead on grant
assign rd_req = (accept && (execute.ctrl.ld || execute.ctrl.st))
              || ((state == READ) && ~(data_gnt && (store_op || last_access)));

// Merged word is ready once in STORE_WR
assign wr_req = (state == STORE_WR);

// ==================================================
// Checks

// Memory must stay quiet while idle or parked
a_no_gnt_idle: assert property (@(posedge clk) disable iff (~rstz)
    (state == WRITE || state == CATCH) |-> ~data_gnt);

// Only reset leaves CATCH
a_catch_sticky: assert property (@(posedge clk) disable iff (~rstz)
    (state == CATCH) |=> (state == CATCH));

// Aligned load finishes after a single read
a_aligned_one_read: assert property (@(posedge clk) disable iff (~rstz)
    (state == READ && data_gnt && ~store_op && ~is_unaligned) |=> (state == LOAD));

endmodule

// ==== source/wb_access_counter.sv ====
// ==================================================
// Word counter and address generator
// At most two aligned words per transaction
// ==================================================
`timescale 1ns/1ns

module wb_access_counter
    import wb_pkg::*;
#(
    parameter int WB_ADDR_W = 32
) (
    input  logic                 clk,
    input  logic                 rstz,
    input  ex_wb_t               execute,
    input  logic                 accept,
    input  wb_state_t            state,
    input  logic                 data_gnt,
    output logic [WB_ADDR_W-1:0] addr,
    output logic                 is_unaligned,
    output logic                 last_access,
    output logic [1:0]           byte_index,
    output wb_ctrl_t             ctrl_q
);

logic [WB_ADDR_W-1:0] base_q;
logic [1:0]           index_q;
logic [1:0]           cnt;
logic [1:0]           cnt_next;
logic                 advance;
access_size_t         size;

// Live values while idle, captured ones during the access
assign byte_index = (state == WRITE) ? execute.result1[1:0] : index_q;
assign size       = (state == WRITE) ? execute.ctrl.data_size : ctrl_q.data_size;

// Access crosses a word boundary
assign is_unaligned = ((size == HALF) && (byte_index == 2'b11))
                    || ((size == WORD) && (byte_index != 2'b00));
assign last_access  = ~is_unaligned || (cnt != 2'd0);

// Move to the next word on the grant of the current one
assign advance  = data_gnt && ~last_access
                && (((state == READ) && ~ctrl_q.st) || (state == STORE_WR));
assign cnt_next = cnt + 2'(advance);

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        cnt    <= 2'd0;
        ctrl_q <= '0;
    end else if (accept) begin
        cnt    <= 2'd0;
        ctrl_q <= execute.ctrl;
    end else begin
        cnt <= cnt_next;
    end
end

// Address payload
always_ff @(posedge clk) begin
    if (accept) begin
        base_q  <= {execute.result1[WB_ADDR_W-1:2], 2'b00};
        index_q <= execute.result1[1:0];
    end
end

// Look-ahead address, valid in the grant cycle
assign addr = (state == WRITE) ? {execute.result1[WB_ADDR_W-1:2], 2'b00}
                               : base_q + (WB_ADDR_W'(cnt_next) << 2);

a_cnt_max: assert property (@(posedge clk) disable iff (~rstz) cnt <= 2'd1);

endmodule

// ==== source/wb_load_align.sv ====
// ==================================================
// Load data alignment and sign extension
// Result valid in the LOAD state only
// ==================================================
`timescale 1ns/1ns

module wb_load_align
    import wb_pkg::*;
(
    input  logic         clk,
    input  logic         rstz,
    input  wb_state_t    state,
    input  logic         data_gnt,
    input  logic [31:0]  data_rd_data,
    input  logic [1:0]   byte_index,
    input  access_size_t size,
    input  logic         sign,
    output logic [31:0]  load_data
);

logic [31:0] word0;
logic [31:0] word1;
logic        have_word0;
logic [63:0] pair_shift;
logic [31:0] raw;

// First grant of the access
always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        have_word0 <= 1'b0;
    end else if (state != READ) begin
        have_word0 <= 1'b0;
    end else if (data_gnt) begin
        have_word0 <= 1'b1;
    end
end

// Word 0 kept, word 1 follows every grant
// Aligned access never reaches into word 1
always_ff @(posedge clk) begin
    if ((state == READ) && data_gnt) begin
        if (~have_word0) begin
            word0 <= data_rd_data;
        end
        word1 <= data_rd_data;
    end
end

// ==================================================
// Shift and extend

assign pair_shift = {word1, word0} >> {byte_index, 3'b000};
assign raw        = pair_shift[31:0];

always_comb begin
    case (size)
        BYTE:    load_data = {{24{sign & raw[7]}}, raw[7:0]};
        HALF:    load_data = {{16{sign & raw[15]}}, raw[15:0]};
        default: load_data = raw;
    endcase
end

endmodule

// ==== source/wb_store_merge.sv ====
// ==================================================
// Read-modify-write merge for stores
// Port has no byte enables, whole words are written
// ==================================================
`timescale 1ns/1ns

module wb_store_merge
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    input  logic        accept,
    input  ex_wb_t      execute,
    input  wb_state_t   state,
    input  logic [1:0]  byte_index,
    input  logic [31:0] data_rd_data,
    output logic [31:0] wr_data
);

logic [63:0] lane_data;
logic [63:0] lane_mask;
logic [63:0] size_mask;
logic [31:0] mem_word;

// Previous cycle was a word write
logic was_store_wr;

// Bytes covered by the access size
always_comb begin
    case (execute.ctrl.data_size)
        BYTE:    size_mask = 64'h0000_0000_0000_00FF;
        HALF:    size_mask = 64'h0000_0000_0000_FFFF;
        default: size_mask = 64'h0000_0000_FFFF_FFFF;
    endcase
end

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        was_store_wr <= 1'b0;
    end else begin
        was_store_wr <= (state == STORE_WR);
    end
end

// ==================================================
// Lane and read word

always_ff @(posedge clk) begin
    if (accept) begin
        // Store data placed in a two-word lane
        lane_data <= 64'(execute.result2) << {byte_index, 3'b000};
        lane_mask <= size_mask << {byte_index, 3'b000};
    end else if ((state == READ) && was_store_wr) begin
        // Upper word becomes current for the second access
        lane_data <= lane_data >> 32;
        lane_mask <= lane_mask >> 32;
    end
end

// Last READ cycle is the grant cycle, so this holds the granted word
always_ff @(posedge clk) begin
    if (state == READ) begin
        mem_word <= data_rd_data;
    end
end

// Lane bytes replace the memory bytes
assign wr_data = (mem_word & ~lane_mask[31:0]) | (lane_data[31:0] & lane_mask[31:0]);

endmodule

// ==== source/wb_commit.sv ====
// ==================================================
// Register write and branch outputs
// Direct results commit in the accept cycle
// ==================================================
`timescale 1ns/1ns

module wb_commit
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    input  wb_state_t   state,
    input  logic        accept,
    input  ex_wb_t      execute,
    input  logic [31:0] load_data,
    input  logic [4:0]  load_rd,
    output logic [31:0] regwr_data,
    output logic [4:0]  regwr_sel,
    output logic        regwr_en,
    output logic [31:0] branch_target,
    output logic        branch
);

logic wb_valid;
logic load_commit;

// Accepted bundle with no memory access
assign wb_valid    = accept && ~execute.ctrl.ld && ~execute.ctrl.st;
assign load_commit = (state == LOAD);

// ==================================================
// Register write from the bundle or the finished load

assign regwr_data = load_commit ? load_data : execute.result1;
assign regwr_sel  = load_commit ? load_rd   : execute.ctrl.rd;
assign regwr_en   = load_commit || (wb_valid && execute.ctrl.rd_write);

// ==================================================
// Branch condition from result1 bit 0

assign branch_target = execute.result2;
assign branch = wb_valid
             && (execute.ctrl.branch || (execute.ctrl.branch_cond && execute.result1[0]));

// No new bundle can sneak in while a load commits
a_load_commit_only: assert property (@(posedge clk) disable iff (~rstz)
    load_commit |-> ~accept);

endmodule

// ==== source/wb_top.sv ====
// ==================================================
// Write-back stage top level
// Memory must grant within WB_MEM_LAT_MAX cycles
// ==================================================
`timescale 1ns/1ns
`include "wb_defs.svh"

module wb_top
    import wb_pkg::*;
#(
    parameter int WB_ADDR_W = 32
) (
    input  logic        clk,
    input  logic        rstz,
    input  ex_wb_t      execute,
    input  logic        pipe_in_vld,
    output logic        pipe_in_rdy,
    output mem_req_t    mem_req,
    input  logic [31:0] data_rd_data,
    input  logic        data_gnt,
    output logic [31:0] regwr_data,
    output logic [4:0]  regwr_sel,
    output logic        regwr_en,
    output logic [31:0] branch_target,
    output logic        branch
);

wb_state_t            state;
logic                 accept;
logic                 rd_req;
logic                 wr_req;
logic [WB_ADDR_W-1:0] word_addr;
logic                 is_unaligned;
logic                 last_access;
logic [1:0]           byte_index;
wb_ctrl_t             ctrl_q;
logic [31:0]          load_data;
logic [31:0]          merged_word;

wb_sequencer u_sequencer (
    .clk, .rstz, .execute, .pipe_in_vld, .data_gnt, .is_unaligned, .last_access,
    .pipe_in_rdy, .state, .accept, .rd_req, .wr_req
);

wb_access_counter #(.WB_ADDR_W(WB_ADDR_W)) u_access_counter (
    .clk, .rstz, .execute, .accept, .state, .data_gnt,
    .addr(word_addr), .is_unaligned, .last_access, .byte_index, .ctrl_q
);

wb_load_align u_load_align (
    .clk, .rstz, .state, .data_gnt, .data_rd_data, .byte_index,
    .size(ctrl_q.data_size), .sign(ctrl_q.data_sign), .load_data
);

wb_store_merge u_store_merge (
    .clk, .rstz, .accept, .execute, .state, .byte_index, .data_rd_data,
    .wr_data(merged_word)
);

wb_commit u_commit (
    .clk, .rstz, .state, .accept, .execute, .load_data, .load_rd(ctrl_q.rd),
    .regwr_data, .regwr_sel, .regwr_en, .branch_target, .branch
);

// Memory request bundle, address zero-extended to the bus width
assign mem_req.addr    = 32'(word_addr);
assign mem_req.wr_data = merged_word;
assign mem_req.rd_req  = rd_req;
assign mem_req.wr_req  = wr_req;

// Outstanding request sees its grant in bounded time
a_gnt_bound: assert property (@(posedge clk) disable iff (~rstz)
    (rd_req || wr_req) |-> ##[0:`WB_MEM_LAT_MAX] data_gnt);

endmodule

// ==== test/wb_mem_model.sv ====
// ==================================================
// Word memory, grant 1 to WB_MEM_LAT_MAX cycles after request
// Addresses wrap at DEPTH words
// ==================================================
`timescale 1ns/1ns
`include "wb_defs.svh"

module wb_mem_model
    import wb_pkg::*;
#(
    parameter int DEPTH   = 64,
    parameter int LAT_MAX = `WB_MEM_LAT_MAX
) (
    input  logic        clk,
    input  logic        rstz,
    input  mem_req_t    mem_req,
    output logic [31:0] data_rd_data,
    output logic        data_gnt
);

localparam int IDX_W = $clog2(DEPTH);

logic [31:0] mem [DEPTH];
logic        busy;
logic        wr_q;
logic [31:0] addr_q;
logic [31:0] wdata_q;
int unsigned wait_q;

// Fill pattern, every word distinct
initial begin
    for (int i = 0; i < DEPTH; i++) begin
        mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    end
end

// Grant when the random wait runs out
assign data_gnt     = busy && (wait_q == 0);
assign data_rd_data = busy ? mem[addr_q[IDX_W+1:2]] : 32'h0;

// ==================================================
// Request capture and completion

// A new request is only taken after the grant cycle of the previous one
always @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        busy   <= 1'b0;
        wait_q <= 0;
    end else if (busy) begin
        if (wait_q == 0) begin
            busy <= 1'b0;
            if (wr_q) begin
                mem[addr_q[IDX_W+1:2]] <= wdata_q;
            end
        end else begin
            wait_q <= wait_q - 1;
        end
    end else if (mem_req.rd_req || mem_req.wr_req) begin
        busy    <= 1'b1;
        wr_q    <= mem_req.wr_req;
        addr_q  <= mem_req.addr;
        wdata_q <= mem_req.wr_data;
        wait_q  <= $urandom_range(LAT_MAX - 1, 0);
    end
end

endmodule

// ==== test/tb_wb.sv ====
// ==================================================
// Testbench for wb_top, random bundles against a byte model
// Accesses stay below byte address 0x100
// ==================================================
`timescale 1ns/1ns
`include "wb_defs.svh"

module tb_wb;
    import wb_pkg::*;

localparam int MEM_DEPTH      = 64;
localparam int NUM_ALU        = 40;
localparam int NUM_BR         = 30;
localparam int NUM_MEM        = 100;
// A store may be followed by a readback load
localparam int NUM_TESTS      = NUM_ALU + NUM_BR + 2 * NUM_MEM + 16;
localparam int TIMEOUT_CYCLES = NUM_TESTS * (4 * `WB_MEM_LAT_MAX + 8);

// Expected commit of one bundle
typedef struct packed {
    logic        reg_wr;
    logic [4:0]  sel;
    logic [31:0] data;
    logic        br;
    logic [31:0] target;
} expect_t;

logic        clk;
logic        rstz;
ex_wb_t      execute;
logic        pipe_in_vld;
logic        pipe_in_rdy;
mem_req_t    mem_req;
logic [31:0] data_rd_data;
logic        data_gnt;
logic [31:0] regwr_data;
logic [4:0]  regwr_sel;
logic        regwr_en;
logic [31:0] branch_target;
logic        branch;

logic [31:0] shadow [MEM_DEPTH];
expect_t     reg_q[$];
expect_t     br_q[$];
expect_t     reg_exp;
expect_t     br_exp;
int          cycle_cnt = 0;

wb_top #(.WB_ADDR_W(32)) u_wb_top (
    .clk, .rstz, .execute, .pipe_in_vld, .pipe_in_rdy, .mem_req, .data_rd_data,
    .data_gnt, .regwr_data, .regwr_sel, .regwr_en, .branch_target, .branch
);

wb_mem_model #(.DEPTH(MEM_DEPTH)) u_mem (
    .clk, .rstz, .mem_req, .data_rd_data, .data_gnt
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// ==================================================
// Failure reporting and compare tasks

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_reg(input logic [4:0] sel_got, input logic [4:0] sel_exp,
                         input logic [31:0] data_got, input logic [31:0] data_exp);
    if (sel_got !== sel_exp) begin
        abort_run($sformatf("ERR regwr_sel got 0x%0h exp 0x%0h", sel_got, sel_exp));
    end
    if (data_got !== data_exp) begin
        abort_run($sformatf("ERR regwr_data got 0x%08h exp 0x%08h", data_got, data_exp));
    end
endtask

task automatic check_branch(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR branch_target got 0x%08h exp 0x%08h", got, exp));
    end
endtask

task automatic check_word(input int idx, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR mem[0x%0h] got 0x%08h exp 0x%08h", idx, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
    end
endtask

// ==================================================
// Reference model, little-endian bytes over the shadow memory

function automatic logic [7:0] read_byte(input logic [31:0] a);
    return shadow[a[7:2]][8 * a[1:0] +: 8];
endfunction

function automatic void write_byte(input logic [31:0] a, input logic [7:0] d);
    shadow[a[7:2]][8 * a[1:0] +: 8] = d;
endfunction

function automatic expect_t model_wb(input ex_wb_t b);
    expect_t     e;
    int          nbytes;
    logic [31:0] val;
    e = '0;
    case (b.ctrl.data_size)
        BYTE:    nbytes = 1;
        HALF:    nbytes = 2;
        default: nbytes = 4;
    endcase
    if (b.ctrl.ld) begin
        val = '0;
        for (int k = 0; k < nbytes; k++) begin
            val[8 * k +: 8] = read_byte(b.result1 + k);
        end
        // Fill the upper bytes with the top bit of the data
        if (b.ctrl.data_sign && (nbytes < 4) && val[8 * nbytes - 1]) begin
            val = val | (32'hFFFF_FFFF << (8 * nbytes));
        end
        e.reg_wr = 1'b1;
        e.sel    = b.ctrl.rd;
        e.data   = val;
    end else if (b.ctrl.st) begin
        for (int k = 0; k < nbytes; k++) begin
            write_byte(b.result1 + k, b.result2[8 * k +: 8]);
        end
    end else begin
        e.reg_wr = b.ctrl.rd_write;
        e.sel    = b.ctrl.rd;
        e.data   = b.result1;
        e.br     = b.ctrl.branch || (b.ctrl.branch_cond && b.result1[0]);
        e.target = b.result2;
    end
    return e;
endfunction

// ==================================================
// Bundle builders

function automatic ex_wb_t make_alu();
    ex_wb_t b;
    b = '0;
    b.result1            = $urandom;
    b.result2            = $urandom;
    b.ctrl.rd            = 5'($urandom);
    b.ctrl.rd_write      = 1'($urandom);
    b.ctrl.data_size     = access_size_t'(2'($urandom % 3));
    b.ctrl.data_sign     = 1'($urandom);
    return b;
endfunction

// Bit 0 of result1 is random, so both condition outcomes show up
function automatic ex_wb_t make_branch();
    ex_wb_t b;
    b = make_alu();
    b.ctrl.branch      = 1'($urandom);
    b.ctrl.branch_cond = 1'($urandom);
    return b;
endfunction

function automatic ex_wb_t make_mem(input logic is_store, input logic [31:0] addr,
                                    input access_size_t size);
    ex_wb_t b;
    b = '0;
    b.result1        = addr;
    b.result2        = $urandom;
    b.ctrl.rd        = 5'($urandom);
    b.ctrl.rd_write  = ~is_store;
    b.ctrl.ld        = ~is_store;
    b.ctrl.st        = is_store;
    b.ctrl.data_size = size;
    b.ctrl.data_sign = 1'($urandom);
    return b;
endfunction

// ==================================================
// Drivers, all entered at a rising edge

task automatic apply_reset();
    #2;
    rstz        = 1'b0;
    pipe_in_vld = 1'b0;
    execute     = '0;
    repeat (3) @(posedge clk);
    #2;
    rstz = 1'b1;
    @(posedge clk);
endtask

task automatic check_idle_outputs();
    check_flag("regwr_en", regwr_en, 1'b0);
    check_flag("branch", branch, 1'b0);
    check_flag("mem_req.rd_req", mem_req.rd_req, 1'b0);
    check_flag("mem_req.wr_req", mem_req.wr_req, 1'b0);
    check_flag("pipe_in_rdy", pipe_in_rdy, 1'b1);
endtask

// Queue the expected commit, then hold the bundle until it is taken
task automatic send_bundle(input ex_wb_t b);
    expect_t e;
    e = model_wb(b);
    if (e.reg_wr) reg_q.push_back(e);
    if (e.br) br_q.push_back(e);
    #2;
    execute     = b;
    pipe_in_vld = 1'b1;
    @(posedge clk);
    while (!pipe_in_rdy) @(posedge clk);
endtask

task automatic wait_idle();
    #2;
    pipe_in_vld = 1'b0;
    execute     = '0;
    @(posedge clk);
    while (!(pipe_in_rdy && (reg_q.size() == 0))) @(posedge clk);
endtask

// ==================================================
// Compare process and timeout

always @(posedge clk) begin
    if (rstz && regwr_en) begin
        if (reg_q.size() == 0) begin
            abort_run($sformatf("Register write to x%0d with none expected", regwr_sel));
        end else begin
            reg_exp = reg_q.pop_front();
            check_reg(regwr_sel, reg_exp.sel, regwr_data, reg_exp.data);
        end
    end
    if (rstz && branch) begin
        if (br_q.size() == 0) begin
            abort_run("Branch taken with none expected");
        end else begin
            br_exp = br_q.pop_front();
            check_branch(branch_target, br_exp.target);
        end
    end
end

always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
end

// ==================================================
// Test sequence

initial begin
    logic [31:0]  addr;
    access_size_t size;
    ex_wb_t       bad;
    void'($urandom(32'h2945));
    rstz        = 1'b0;
    pipe_in_vld = 1'b0;
    execute     = '0;
    apply_reset();
    check_idle_outputs();
    for (int i = 0; i < MEM_DEPTH; i++) begin
        shadow[i] = u_mem.mem[i];
    end

    repeat (NUM_ALU) send_bundle(make_alu());
    repeat (NUM_BR) send_bundle(make_branch());

    // Mixed loads and stores, some stores read straight back
    repeat (NUM_MEM) begin
        addr = $urandom % 248;
        size = access_size_t'(2'($urandom % 3));
        if ($urandom % 2) begin
            send_bundle(make_mem(1'b1, addr, size));
            if ($urandom % 2) send_bundle(make_mem(1'b0, addr, size));
        end else begin
            send_bundle(make_mem(1'b0, addr, size));
        end
    end
    wait_idle();
    for (int i = 0; i < MEM_DEPTH; i++) begin
        check_word(i, u_mem.mem[i], shadow[i]);
    end

    // Illegal bundle parks the stage, later bundles are ignored
    bad              = make_alu();
    bad.ctrl.illegal = 1'b1;
    #2;
    execute     = bad;
    pipe_in_vld = 1'b1;
    @(posedge clk);
    check_flag("pipe_in_rdy", pipe_in_rdy, 1'b0);
    #2;
    execute = make_branch();
    repeat (6) begin
        @(posedge clk);
        check_flag("pipe_in_rdy", pipe_in_rdy, 1'b0);
    end
    apply_reset();
    check_idle_outputs();

    if ((reg_q.size() != 0) || (br_q.size() != 0)) begin
        abort_run("Expected register writes or branches never appeared");
    end else begin
        $display("Result: PASSED");
        $finish;
    end
end

endmodule

// ==== wbstage.f ====
+incdir+include
source/wb_pkg.sv
source/wb_sequencer.sv
source/wb_access_counter.sv
source/wb_load_align.sv
source/wb_store_merge.sv
source/wb_commit.sv
source/wb_top.sv
test/wb_mem_model.sv
test/tb_wb.sv
